// File: tests/div_tests.txt
// columns: port signed dividend divisor quotient remainder
// all values hex, one vector per line
0 0 00000064 00000007 0000000e 00000002
1 0 ffffffff 00000010 0fffffff 0000000f
0 0 12345678 00000001 12345678 00000000
1 0 00000005 00000009 00000000 00000005
0 0 80000000 00000003 2aaaaaaa 00000002
1 0 deadbeef 00000000 ffffffff deadbeef
0 1 00000007 00000002 00000003 00000001
1 1 fffffff9 00000002 fffffffd ffffffff
0 1 00000007 fffffffe fffffffd 00000001
1 1 fffffff9 fffffffe 00000003 ffffffff
0 1 80000000 ffffffff 80000000 00000000
1 1 fffffff6 00000000 ffffffff fffffff6
0 1 80000000 00000001 80000000 00000000
1 1 00000064 ffffff9c ffffffff 00000000
0 0 fffffffe ffffffff 00000000 fffffffe
1 1 80000001 00000010 f8000001 fffffff1

// File: project.f
+incdir+include
hdl/arith_pkg.sv
hdl/bus_pkg.sv
hdl/restoring_divider.sv
hdl/signed_div_wrapper.sv
hdl/apb_div_port.sv
hdl/div_arbiter.sv
hdl/div_subsystem_top.sv
tests/div_asserts.sv
tests/tb_div_subsystem.sv

// File: Makefile
SRCS := $(filter-out +%,$(shell cat project.f))
HDRS := $(wildcard include/*.svh)

.PHONY: run clean

run: obj_dir/Vtb_div_subsystem
	@out="$$(./obj_dir/Vtb_div_subsystem)"; echo "$$out"; \
	echo "$$out" | grep -q "Regression passed"

obj_dir/Vtb_div_subsystem: project.f $(SRCS) $(HDRS) tests/div_tests.txt
	verilator --binary --timing --assert -f project.f --top-module tb_div_subsystem

clean:
	rm -rf obj_dir

// File: tests/tb_div_subsystem.sv
`timescale 1ns/1ns
`include "div_cfg.svh"

module tb_div_subsystem;

    localparam int num_vec  = 16;     // lines in the vector file
    localparam int num_rand = 8;
    // two slots of DIV_ITER+10 cycles per divide plus reset and error traffic
    localparam int max_cycles = (num_vec + num_rand + 3) * (`DIV_ITER + 10) * 2 + 200;

    logic               clk;
    logic               reset;
    logic               psel [2];
    logic               penable [2];
    logic               pwrite [2];
    bus_pkg::apb_addr_t paddr [2];
    arith_pkg::word_t   pwdata [2];
    arith_pkg::word_t   prdata [2];
    logic               pready [2];
    logic               pslverr [2];
    arith_pkg::word_t   vectors [0:num_vec*6-1];
    int                 seed = 32'h43bf_4d88;
    int                 cycles = 0;
    bus_pkg::apb_addr_t reg_map [6] = '{`REG_DIVIDEND, `REG_DIVISOR, `REG_CTRL,
                                        `REG_STATUS, `REG_QUOT, `REG_REM};

    div_subsystem_top uut (
        .clk (clk), .reset (reset),
        .psel_0 (psel[0]), .penable_0 (penable[0]), .pwrite_0 (pwrite[0]),
        .paddr_0 (paddr[0]), .pwdata_0 (pwdata[0]), .prdata_0 (prdata[0]),
        .pready_0 (pready[0]), .pslverr_0 (pslverr[0]),
        .psel_1 (psel[1]), .penable_1 (penable[1]), .pwrite_1 (pwrite[1]),
        .paddr_1 (paddr[1]), .pwdata_1 (pwdata[1]), .prdata_1 (prdata[1]),
        .pready_1 (pready[1]), .pslverr_1 (pslverr[1])
    );

    bind div_arbiter div_asserts arb_checks (
        .clk (clk), .reset (reset), .req0 (req0), .req1 (req1),
        .gnt0 (gnt0), .gnt1 (gnt1), .start (start), .done (done_in)
    );

    bind signed_div_wrapper div_asserts #(.check_grants (1'b0)) wrap_checks (
        .clk (clk), .reset (reset), .req0 (1'b0), .req1 (1'b0),
        .gnt0 (1'b0), .gnt1 (1'b0), .start (start), .done (done)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= max_cycles) begin
            $display("timeout: the tests did not finish within %0d cycles", max_cycles);
            $display("Regression failed");
            $fatal(1, "simulation stopped by the cycle limit");
        end
    end

    task automatic check(input arith_pkg::word_t got, input arith_pkg::word_t exp,
                         input string what);
        if (got !== exp) begin
            $display("FAILED at %0t ns: %s got %h expected %h", $time, what, got, exp);
            $display("Regression failed");
            $fatal(1, "stopped at the first mismatch");
        end
    endtask

    task automatic apb_xfer(input int p, input logic write, input bus_pkg::apb_addr_t addr,
                            input arith_pkg::word_t wdata, output arith_pkg::word_t rdata,
                            output logic err);
        @(posedge clk);
        psel[p]    <= 1'b1;           // setup phase
        penable[p] <= 1'b0;
        pwrite[p]  <= write;
        paddr[p]   <= addr;
        pwdata[p]  <= wdata;
        @(posedge clk);
        penable[p] <= 1'b1;
        @(negedge clk);
        rdata = prdata[p];            // mid access phase where outputs have settled
        err   = pslverr[p];
        check({31'b0, pready[p]}, 32'd1, "pready during access");
        @(posedge clk);
        psel[p]    <= 1'b0;
        penable[p] <= 1'b0;
    endtask

    task automatic write_reg(input int p, input bus_pkg::apb_addr_t addr,
                             input arith_pkg::word_t data);
        arith_pkg::word_t rd;
        logic             err;
        apb_xfer(p, 1'b1, addr, data, rd, err);
        check({31'b0, err}, 32'd0, $sformatf("pslverr on port %0d write to %h", p, addr));
    endtask

    task automatic read_reg(input int p, input bus_pkg::apb_addr_t addr,
                            output arith_pkg::word_t data);
        logic err;
        apb_xfer(p, 1'b0, addr, '0, data, err);
        check({31'b0, err}, 32'd0, $sformatf("pslverr on port %0d read of %h", p, addr));
    endtask

    // expected {quotient, remainder} by the RISC-V divide rules
    function automatic logic [63:0] model_divide(input logic sgn, input arith_pkg::word_t a,
                                                 input arith_pkg::word_t b);
        int sa;
        int sb;
        sa = int'(a);
        sb = int'(b);
        if (b == '0) begin
            return {32'hffff_ffff, a};
        end
        if (!sgn) begin
            return {a / b, a % b};
        end
        if (a == 32'h8000_0000 && b == 32'hffff_ffff) begin
            return {a, 32'h0};        // overflow keeps the dividend
        end
        return {sa / sb, sa % sb};    // int division truncates toward zero
    endfunction

    task automatic wait_done(input int p);
        arith_pkg::word_t st;
        st = '0;
        while (!st[1]) begin
            read_reg(p, `REG_STATUS, st);
        end
        check(st, 32'h2, $sformatf("port %0d status at done", p));
    endtask

    task automatic check_result(input int p, input logic [63:0] exp, input string what);
        arith_pkg::word_t rd;
        read_reg(p, `REG_QUOT, rd);
        check(rd, exp[63:32], $sformatf("port %0d quotient of %s", p, what));
        read_reg(p, `REG_REM, rd);
        check(rd, exp[31:0], $sformatf("port %0d remainder of %s", p, what));
    endtask

    task automatic run_div(input int p, input logic sgn, input arith_pkg::word_t a,
                           input arith_pkg::word_t b, input logic [63:0] exp);
        write_reg(p, `REG_DIVIDEND, a);
        write_reg(p, `REG_DIVISOR, b);
        write_reg(p, `REG_CTRL, {30'b0, sgn, 1'b1});
        wait_done(p);
        check_result(p, exp, $sformatf("%h / %h signed %0d", a, b, sgn));
    endtask

    initial begin
        arith_pkg::word_t a;
        arith_pkg::word_t b;
        arith_pkg::word_t rd;
        logic             sgn;
        logic             err;

        $readmemh("tests/div_tests.txt", vectors);
        reset = 1'b1;
        for (int k = 0; k < 2; k++) begin
            psel[k]    = 1'b0;
            penable[k] = 1'b0;
            pwrite[k]  = 1'b0;
            paddr[k]   = '0;
            pwdata[k]  = '0;
        end
        repeat (4) @(posedge clk);
        reset <= 1'b0;

        for (int p = 0; p < 2; p++) begin
            for (int k = 0; k < 6; k++) begin
                read_reg(p, reg_map[k], rd);
                check(rd, '0, $sformatf("port %0d register %h after reset", p, reg_map[k]));
            end
        end

        for (int i = 0; i < num_vec; i++) begin
            run_div(int'(vectors[6*i]), vectors[6*i+1][0], vectors[6*i+2], vectors[6*i+3],
                    {vectors[6*i+4], vectors[6*i+5]});
        end

        for (int i = 0; i < num_rand; i++) begin
            a   = $random(seed);
            b   = $random(seed);
            sgn = i[1];
            if (i[0]) begin
                b = b >> (i + 16);    // small divisors give long quotients
            end
            run_div(i % 2, sgn, a, b, model_divide(sgn, a, b));
        end

        // both windows start in the same cycle
        write_reg(0, `REG_DIVIDEND, 32'hffff_f000);
        write_reg(0, `REG_DIVISOR, 32'h0000_0030);
        write_reg(1, `REG_DIVIDEND, 32'h0000_abcd);
        write_reg(1, `REG_DIVISOR, 32'h0000_0123);
        fork
            write_reg(0, `REG_CTRL, 32'h3);
            write_reg(1, `REG_CTRL, 32'h1);
        join
        wait_done(0);
        wait_done(1);
        check_result(0, model_divide(1'b1, 32'hffff_f000, 32'h30), "contended signed divide");
        check_result(1, model_divide(1'b0, 32'h0000_abcd, 32'h123), "contended divide");

        write_reg(0, `REG_DIVIDEND, 32'hffff_0000);
        write_reg(0, `REG_DIVISOR, 32'h0000_0010);
        write_reg(0, `REG_CTRL, 32'h1);
        apb_xfer(0, 1'b1, `REG_CTRL, 32'h3, rd, err);
        check({31'b0, err}, 32'd1, "pslverr on ctrl write while busy");
        read_reg(0, `REG_STATUS, rd);
        check(rd, 32'h1, "status while the divide runs");
        apb_xfer(0, 1'b1, 8'h18, 32'h1234_5678, rd, err);
        check({31'b0, err}, 32'd1, "pslverr on unmapped write");
        apb_xfer(0, 1'b0, 8'h40, '0, rd, err);
        check({31'b0, err}, 32'd1, "pslverr on unmapped read");
        read_reg(0, `REG_DIVIDEND, rd);
        check(rd, 32'hffff_0000, "dividend after error transfers");
        read_reg(0, `REG_DIVISOR, rd);
        check(rd, 32'h0000_0010, "divisor after error transfers");
        wait_done(0);
        check_result(0, model_divide(1'b0, 32'hffff_0000, 32'h10), "divide with errors");

        $display("Regression passed");
        $finish;
    end

endmodule

// File: tests/div_asserts.sv
`timescale 1ns/1ns
`include "div_cfg.svh"

module div_asserts #(
    parameter bit check_grants = 1'b1   // grant checks apply to the arbiter only
) (
    input logic clk,
    input logic reset,
    input logic req0,
    input logic req1,
    input logic gnt0,
    input logic gnt1,
    input logic start,
    input logic done
);

    logic       pending;      // start seen and done not yet
    logic [7:0] waited;

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= 1'b0;
            waited  <= '0;
        end else if (start) begin
            pending <= 1'b1;
            waited  <= 8'd1;
        end else if (done) begin
            pending <= 1'b0;
        end else if (pending) begin
            waited <= waited + 8'd1;
        end
    end

    if (check_grants) begin : grant_checks
        grant_exclusive: assert property (@(posedge clk) disable iff (reset)
            !(gnt0 && gnt1) && (!gnt0 || req0) && (!gnt1 || req1))
            else $error("grant to both ports or to a port without a request");
    end

    start_when_free: assert property (@(posedge clk) disable iff (reset) start |-> !pending)
        else $error("start while a divide is still running");

    done_in_time: assert property (@(posedge clk) disable iff (reset)
        pending |-> (waited <= 8'(`DIV_ITER + 2)))
        else $error("done missing within DIV_ITER+2 cycles of start");

endmodule

// File: hdl/div_subsystem_top.sv
`timescale 1ns/1ns

module div_subsystem_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel_0,
    input  logic               penable_0,
    input  logic               pwrite_0,
    input  bus_pkg::apb_addr_t paddr_0,
    input  arith_pkg::word_t   pwdata_0,
    output arith_pkg::word_t   prdata_0,
    output logic               pready_0,
    output logic               pslverr_0,
    input  logic               psel_1,
    input  logic               penable_1,
    input  logic               pwrite_1,
    input  bus_pkg::apb_addr_t paddr_1,
    input  arith_pkg::word_t   pwdata_1,
    output arith_pkg::word_t   prdata_1,
    output logic               pready_1,
    output logic               pslverr_1
);

    logic             req0, req1, gnt0, gnt1, res_done0, res_done1;
    logic             a_signed0, a_signed1, start, signed_div, done;
    arith_pkg::word_t a_dividend0, a_divisor0, a_dividend1, a_divisor1;
    arith_pkg::word_t dividend, divisor, quotient, remainder;

    apb_div_port port0 (
        .clk (clk), .reset (reset),
        .psel (psel_0), .penable (penable_0), .pwrite (pwrite_0),
        .paddr (paddr_0), .pwdata (pwdata_0), .prdata (prdata_0),
        .pready (pready_0), .pslverr (pslverr_0),
        .req (req0), .gnt (gnt0), .res_done (res_done0),
        .a_dividend (a_dividend0), .a_divisor (a_divisor0), .a_signed (a_signed0),
        .res_quot (quotient), .res_rem (remainder)      // shared result bus
    );

    apb_div_port port1 (
        .clk (clk), .reset (reset),
        .psel (psel_1), .penable (penable_1), .pwrite (pwrite_1),
        .paddr (paddr_1), .pwdata (pwdata_1), .prdata (prdata_1),
        .pready (pready_1), .pslverr (pslverr_1),
        .req (req1), .gnt (gnt1), .res_done (res_done1),
        .a_dividend (a_dividend1), .a_divisor (a_divisor1), .a_signed (a_signed1),
        .res_quot (quotient), .res_rem (remainder)
    );

    div_arbiter arb (
        .clk (clk), .reset (reset),
        .req0 (req0), .req1 (req1),
        .a_dividend0 (a_dividend0), .a_divisor0 (a_divisor0),
        .a_dividend1 (a_dividend1), .a_divisor1 (a_divisor1),
        .a_signed0 (a_signed0), .a_signed1 (a_signed1),
        .gnt0 (gnt0), .gnt1 (gnt1),
        .start (start), .signed_div (signed_div),
        .dividend (dividend), .divisor (divisor),
        .done_in (done), .res_done0 (res_done0), .res_done1 (res_done1)
    );

    signed_div_wrapper wrap (
        .clk (clk), .reset (reset),
        .start (start), .signed_div (signed_div),
        .dividend (dividend), .divisor (divisor),
        .quotient (quotient), .remainder (remainder), .done (done)
    );

endmodule

// File: hdl/div_arbiter.sv
`timescale 1ns/1ns

module div_arbiter (
    input  logic              clk,
    input  logic              reset,
    input  logic              req0,
    input  logic              req1,
    input  arith_pkg::word_t  a_dividend0,
    input  arith_pkg::word_t  a_divisor0,
    input  arith_pkg::word_t  a_dividend1,
    input  arith_pkg::word_t  a_divisor1,
    input  logic              a_signed0,
    input  logic              a_signed1,
    output logic              gnt0,
    output logic              gnt1,
    output logic              start,
    output logic              signed_div,
    output arith_pkg::word_t  dividend,
    output arith_pkg::word_t  divisor,
    input  logic              done_in,
    output logic              res_done0,
    output logic              res_done1
);

    bus_pkg::port_id_t owner;
    bus_pkg::port_id_t pick;
    logic              last;       // winner of the previous grant
    logic              active;     // divide running from grant to done
    logic              gnt_r;
    logic              grant_now;

    always_comb begin
        if (req0 && req1) begin
            pick = ~last;          // alternate under contention
        end else begin
            pick = req1;
        end
    end

    assign grant_now = ~active & (req0 | req1);

    always_ff @(posedge clk) begin
        if (reset) begin
            owner  <= 1'b0;
            last   <= 1'b1;        // port 0 first after reset
            active <= 1'b0;
            gnt_r  <= 1'b0;
        end else begin
            gnt_r <= grant_now;
            if (grant_now) begin
                owner  <= pick;
                last   <= pick;
                active <= 1'b1;
            end else if (done_in) begin
                active <= 1'b0;
            end
        end
    end

    assign gnt0       = gnt_r & (owner == 1'b0);
    assign gnt1       = gnt_r & (owner == 1'b1);
    assign start      = gnt_r;
    assign dividend   = owner ? a_dividend1 : a_dividend0;   // steer the owner's operands
    assign divisor    = owner ? a_divisor1 : a_divisor0;
    assign signed_div = owner ? a_signed1 : a_signed0;
    assign res_done0  = done_in & active & (owner == 1'b0);
    assign res_done1  = done_in & active & (owner == 1'b1);

endmodule

// File: hdl/apb_div_port.sv
`timescale 1ns/1ns
`include "div_cfg.svh"

module apb_div_port (
    input  logic               clk,
    input  logic               reset,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  bus_pkg::apb_addr_t paddr,
    input  arith_pkg::word_t   pwdata,
    output arith_pkg::word_t   prdata,
    output logic               pready,
    output logic               pslverr,
    output logic               req,
    input  logic               gnt,
    input  logic               res_done,
    output arith_pkg::word_t   a_dividend,
    output arith_pkg::word_t   a_divisor,
    output logic               a_signed,
    input  arith_pkg::word_t   res_quot,
    input  arith_pkg::word_t   res_rem
);

    bus_pkg::port_state_t state;
    bus_pkg::reg_sel_t    sel;
    arith_pkg::word_t     dividend_r;
    arith_pkg::word_t     divisor_r;
    arith_pkg::word_t     quot_r;
    arith_pkg::word_t     rem_r;
    logic                 signed_r;
    logic                 access;
    logic                 in_flight;
    logic                 wr_ok;

    always_comb begin
        sel = '0;
        case (paddr)
            `REG_DIVIDEND: sel[0] = 1'b1;
            `REG_DIVISOR:  sel[1] = 1'b1;
            `REG_CTRL:     sel[2] = 1'b1;
            `REG_STATUS:   sel[3] = 1'b1;
            `REG_QUOT:     sel[4] = 1'b1;
            `REG_REM:      sel[5] = 1'b1;
            default:       sel    = '0;   // unmapped
        endcase
    end

    assign pready    = 1'b1;              // no wait states
    assign access    = psel & penable;
    assign in_flight = (state == bus_pkg::wait_grant) || (state == bus_pkg::busy);
    assign pslverr   = access & (~(|sel) | (pwrite & sel[2] & in_flight));
    assign wr_ok     = access & pwrite & ~pslverr;

    always_comb begin
        prdata = '0;                      // ctrl reads back as zero
        if (sel[0]) prdata = dividend_r;
        if (sel[1]) prdata = divisor_r;
        if (sel[3]) prdata = {{(`DIV_WIDTH-2){1'b0}}, state == bus_pkg::done, in_flight};
        if (sel[4]) prdata = quot_r;
        if (sel[5]) prdata = rem_r;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= bus_pkg::idle;
            dividend_r <= '0;
            divisor_r  <= '0;
            signed_r   <= 1'b0;
            quot_r     <= '0;
            rem_r      <= '0;
        end else begin
            // operands held steady while a divide is pending
            if (wr_ok && sel[0] && !in_flight) dividend_r <= pwdata;
            if (wr_ok && sel[1] && !in_flight) divisor_r <= pwdata;
            if (wr_ok && sel[2]) signed_r <= pwdata[1];
            case (state)
                bus_pkg::idle, bus_pkg::done: begin
                    if (wr_ok && sel[2] && pwdata[0]) state <= bus_pkg::wait_grant;
                end
                bus_pkg::wait_grant: begin
                    if (gnt) state <= bus_pkg::busy;
                end
                bus_pkg::busy: begin
                    if (res_done) begin
                        state  <= bus_pkg::done;
                        quot_r <= res_quot;   // shared result bus, ours only on res_done
                        rem_r  <= res_rem;
                    end
                end
                default: state <= bus_pkg::idle;
            endcase
        end
    end

    assign req        = (state == bus_pkg::wait_grant);
    assign a_dividend = dividend_r;
    assign a_divisor  = divisor_r;
    assign a_signed   = signed_r;

endmodule

// File: hdl/signed_div_wrapper.sv
`timescale 1ns/1ns
`include "div_cfg.svh"

module signed_div_wrapper (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  logic              signed_div,
    input  arith_pkg::word_t  dividend,
    input  arith_pkg::word_t  divisor,
    output arith_pkg::word_t  quotient,
    output arith_pkg::word_t  remainder,
    output logic              done
);

    arith_pkg::word_t mag_dividend;
    arith_pkg::word_t mag_divisor;
    arith_pkg::word_t core_quot;
    arith_pkg::word_t core_rem;
    logic             sign_a;
    logic             sign_b;
    logic             div_zero;
    logic             core_start;
    logic             core_busy;
    logic             pend_r;        // core run in flight
    logic             neg_quot_r;
    logic             neg_rem_r;
    logic             finish;

    assign sign_a       = signed_div & dividend[`DIV_WIDTH-1];
    assign sign_b       = signed_div & divisor[`DIV_WIDTH-1];
    assign mag_dividend = sign_a ? -dividend : dividend;
    assign mag_divisor  = sign_b ? -divisor : divisor;
    assign div_zero     = (divisor == '0);
    assign core_start   = start & ~div_zero;    // zero divisor bypasses the core
    assign finish       = pend_r & ~core_busy;  // first cycle after busy falls

    restoring_divider core (
        .clk       (clk),
        .reset     (reset),
        .start     (core_start),
        .dividend  (mag_dividend),
        .divisor   (mag_divisor),
        .quotient  (core_quot),
        .remainder (core_rem),
        .busy      (core_busy)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            pend_r     <= 1'b0;
            neg_quot_r <= 1'b0;
            neg_rem_r  <= 1'b0;
            done       <= 1'b0;
            quotient   <= '0;
            remainder  <= '0;
        end else begin
            done <= finish | (start & div_zero);
            if (core_start) begin
                pend_r     <= 1'b1;
                neg_quot_r <= sign_a ^ sign_b;
                neg_rem_r  <= sign_a;              // remainder follows the dividend
            end else if (finish) begin
                pend_r <= 1'b0;
            end
            if (start && div_zero) begin
                quotient  <= '1;
                remainder <= dividend;
            end else if (finish) begin
                quotient  <= neg_quot_r ? -core_quot : core_quot;
                remainder <= neg_rem_r ? -core_rem : core_rem;
            end
        end
    end

endmodule

// File: hdl/restoring_divider.sv
`timescale 1ns/1ns
`include "div_cfg.svh"

module restoring_divider (
    input  logic              clk,
    input  logic              reset,
    input  logic              start,
    input  arith_pkg::word_t  dividend,
    input  arith_pkg::word_t  divisor,
    output arith_pkg::word_t  quotient,
    output arith_pkg::word_t  remainder,
    output logic              busy
);

    arith_pkg::div_state_t state;
    arith_pkg::count_t     count;
    arith_pkg::word_t      rem_hi;    // partial remainder
    arith_pkg::word_t      rem_lo;    // dividend bits shifting out, quotient bits in
    arith_pkg::word_t      div_r;
    arith_pkg::word_t      shifted;
    arith_pkg::word_t      next_hi;
    logic [`DIV_WIDTH:0]   diff;      // extra bit catches the borrow
    logic                  keep;
    logic                  load;

    assign load = (state == arith_pkg::idle) && start;   // start ignored while running

    always_comb begin
        shifted = {rem_hi[`DIV_WIDTH-2:0], rem_lo[`DIV_WIDTH-1]};
        diff    = {1'b0, shifted} - {1'b0, div_r};
        // a set top bit means the shifted value already exceeds the divisor
        keep    = rem_hi[`DIV_WIDTH-1] | ~diff[`DIV_WIDTH];
        next_hi = keep ? diff[`DIV_WIDTH-1:0] : shifted;
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= arith_pkg::idle;
            count <= '0;
        end else begin
            case (state)
                arith_pkg::idle: begin
                    if (start) begin
                        state <= arith_pkg::run;
                        count <= '0;
                    end
                end
                arith_pkg::run: begin
                    count <= count + 1'b1;
                    if (count == arith_pkg::count_t'(`DIV_ITER - 1)) begin
                        state <= arith_pkg::idle;   // last quotient bit this cycle
                    end
                end
                default: state <= arith_pkg::idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            rem_hi <= '0;
            rem_lo <= dividend;
            div_r  <= divisor;
        end else if (state == arith_pkg::run) begin
            rem_hi <= next_hi;
            rem_lo <= {rem_lo[`DIV_WIDTH-2:0], keep};
        end
    end

    assign busy      = (state == arith_pkg::run);
    assign quotient  = rem_lo;
    assign remainder = rem_hi;

endmodule

// File: hdl/bus_pkg.sv
`include "div_cfg.svh"

package bus_pkg;

    typedef logic [`APB_ADDR_W-1:0] apb_addr_t;

    // one-hot register select: dividend, divisor, ctrl, status, quot, rem
    typedef logic [5:0] reg_sel_t;

    typedef logic port_id_t;   // requester index

    typedef enum logic [1:0] {
        idle,
        wait_grant,
        busy,
        done
    } port_state_t;

endpackage

// File: hdl/arith_pkg.sv
`include "div_cfg.svh"

package arith_pkg;

    // one data word on the divide datapath
    typedef logic [`DIV_WIDTH-1:0] word_t;

    // iteration counter of the core
    typedef logic [$clog2(`DIV_ITER)-1:0] count_t;

    // core sequencing
    typedef enum logic {
        idle,
        run
    } div_state_t;

endpackage

// File: include/div_cfg.svh
`ifndef DIV_CFG_SVH
`define DIV_CFG_SVH

`define DIV_WIDTH    32           // operand width
`define DIV_ITER     `DIV_WIDTH   // one quotient bit per cycle
`define APB_ADDR_W   8

// register window offsets
`define REG_DIVIDEND 8'h00
`define REG_DIVISOR  8'h04
`define REG_CTRL     8'h08        // write only: bit 0 start, bit 1 signed
`define REG_STATUS   8'h0C        // bit 0 busy, bit 1 done
`define REG_QUOT     8'h10
`define REG_REM      8'h14

`endif
